// File: logic/acc_pkg.sv
`default_nettype none

package acc_pkg;

  localparam int ADDR_W          = 10;
  localparam int QTD_W           = 10;
  localparam int ID_W            = 2;
  localparam int LINE_W          = 64;
  localparam int NUM_QUEUES      = 2;
  localparam int FIFO_DEPTH_BITS = 4;
  localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_BITS;

  typedef logic [LINE_W-1:0] line_t;

  // one host word per queue.
  typedef struct packed {
    logic [ADDR_W-1:0] addr_base;
    logic [QTD_W-1:0]  qtd;
    logic [ID_W-1:0]   queue_id;
  } conf_word_t;

  // wishbone classic, read only.
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic [ADDR_W-1:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    line_t dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: logic/conf_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module conf_receiver import acc_pkg::*; (
  input  wire                    clk,
  input  wire                    rst_internal,
  input  wire                    conf_valid,
  input  wire conf_word_t        conf,
  output logic [NUM_QUEUES-1:0]  queue_conf_valid,
  output conf_word_t             queue_conf
);

  // one-hot pulse where an id past the last queue matches no bit.
  always_ff @(posedge clk) begin
    if (rst_internal) begin
      queue_conf_valid <= '0;
    end else begin
      for (int i = 0; i < NUM_QUEUES; i++) begin
        queue_conf_valid[i] <= conf_valid && (conf.queue_id == ID_W'(i));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (conf_valid) begin
      queue_conf <= conf;  // held for the queue to latch.
    end
  end

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo import acc_pkg::*; (
  input  wire                       clk,
  input  wire                       rst_internal,
  input  wire                       we,
  input  wire line_t                din,
  input  wire                       re,
  output logic                      valid,
  output line_t                     dout,
  output logic [FIFO_DEPTH_BITS:0]  count,
  output logic                      empty,
  output logic                      full
);

  line_t                      mem [FIFO_DEPTH];
  logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic                       do_wr;
  logic                       do_rd;

  assign empty = (count == '0);
  assign full  = (count == (FIFO_DEPTH_BITS+1)'(FIFO_DEPTH));
  assign do_wr = we && !full;   // write on full is dropped.
  assign do_rd = re && !empty;  // pop on empty is dropped.

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (do_rd) begin
      dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      valid <= do_rd;  // lines up with dout.
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth.
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/input_queue_controller.sv
`timescale 1ns/1ns
`default_nettype none

module input_queue_controller import acc_pkg::*; #(
  parameter int QUEUE_ID = 0
) (
  input  wire                    clk,
  input  wire                    rst_internal,
  input  wire                    start,
  input  wire [NUM_QUEUES-1:0]   conf_valid,
  input  wire conf_word_t        conf,
  output wb_req_t                wb_req,
  input  wire wb_rsp_t           wb_rsp,
  input  wire                    user_rd,
  output line_t                  user_data,
  output logic                   user_valid,
  output logic                   user_avail,
  output logic                   done
);

  logic                     configured;
  logic [ADDR_W-1:0]        next_addr;
  logic [QTD_W-1:0]         qtd;
  logic [QTD_W-1:0]         req_cnt;
  logic [QTD_W-1:0]         arr_cnt;
  logic [FIFO_DEPTH_BITS:0] pending;
  logic                     my_conf;
  logic                     issue;
  logic                     pop;
  logic                     fifo_empty;

  assign my_conf    = conf_valid[QUEUE_ID];
  assign pop        = user_rd && !fifo_empty;
  assign user_avail = !fifo_empty;

  // one read in flight, and never more lines owed than the fifo holds.
  assign issue = start && configured && !wb_req.cyc && (req_cnt < qtd)
                 && (pending < (FIFO_DEPTH_BITS+1)'(FIFO_DEPTH));

  //////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      configured <= 1'b0;
    end else if (my_conf) begin
      configured <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (my_conf) begin
      qtd <= conf.qtd;
    end
  end

  always_ff @(posedge clk) begin
    if (my_conf) begin
      next_addr <= conf.addr_base;
    end else if (issue) begin
      next_addr <= next_addr + 1'b1;  // one line per request.
    end
  end

  //////////////////////////////////////////////////
  // bus master
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      wb_req  <= '0;
      req_cnt <= '0;
    end else if (issue) begin
      wb_req.cyc <= 1'b1;
      wb_req.stb <= 1'b1;
      wb_req.adr <= next_addr;
      req_cnt    <= req_cnt + 1'b1;
    end else if (wb_rsp.ack) begin
      wb_req.cyc <= 1'b0;  // idle at least one cycle before the next.
      wb_req.stb <= 1'b0;
    end
  end

  // requested but not yet popped by the user.
  always_ff @(posedge clk) begin
    if (rst_internal) begin
      pending <= '0;
    end else begin
      case ({issue, pop})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      arr_cnt <= '0;
      done    <= 1'b0;
    end else begin
      if (wb_rsp.ack) begin
        arr_cnt <= arr_cnt + 1'b1;
      end
      if (start && configured && (arr_cnt == qtd)) begin
        done <= 1'b1;  // sticky.
      end
    end
  end

  sync_fifo u_fifo (
    .clk          (clk),
    .rst_internal (rst_internal),
    .we           (wb_rsp.ack),
    .din          (wb_rsp.dat),
    .re           (user_rd),
    .valid        (user_valid),
    .dout         (user_data),
    .count        (),
    .empty        (fifo_empty),
    .full         ()
  );

endmodule

`default_nettype wire

// File: logic/read_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module read_arbiter import acc_pkg::*; (
  input  wire                            clk,
  input  wire                            rst_internal,
  input  wire wb_req_t [NUM_QUEUES-1:0]  m_req,
  output wb_rsp_t      [NUM_QUEUES-1:0]  m_rsp,
  output wb_req_t                        s_req,
  input  wire wb_rsp_t                   s_rsp
);

  logic            busy;
  logic [ID_W-1:0] grant;
  logic [ID_W-1:0] last;
  logic [ID_W-1:0] pick;
  logic            pick_valid;

  // first requester after the one served last.
  always_comb begin
    int unsigned idx;
    pick_valid = 1'b0;
    pick       = last;
    for (int k = 1; k <= NUM_QUEUES; k++) begin
      idx = (int'(last) + k) % NUM_QUEUES;
      if (!pick_valid && m_req[idx].cyc) begin
        pick_valid = 1'b1;
        pick       = ID_W'(idx);
      end
    end
  end

  //////////////////////////////////////////////////
  // grant and registered slave request
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      busy  <= 1'b0;
      grant <= '0;
      last  <= ID_W'(NUM_QUEUES - 1);  // queue 0 wins first.
      s_req <= '0;
    end else if (!busy) begin
      if (pick_valid) begin
        busy  <= 1'b1;
        grant <= pick;
        last  <= pick;
        s_req <= m_req[pick];
      end
    end else if (s_rsp.ack || !m_req[grant].cyc) begin
      busy  <= 1'b0;  // master drops cyc on this same edge.
      s_req <= '0;
    end else begin
      s_req <= m_req[grant];
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_QUEUES; i++) begin
      m_rsp[i].dat = s_rsp.dat;  // data fans out while only ack is steered.
      m_rsp[i].ack = s_rsp.ack && busy && (grant == ID_W'(i));
    end
  end

endmodule

`default_nettype wire

// File: logic/line_memory.sv
`timescale 1ns/1ns
`default_nettype none

module line_memory import acc_pkg::*; (
  input  wire                clk,
  input  wire                rst_internal,
  input  wire                load_en,
  input  wire [ADDR_W-1:0]   load_addr,
  input  wire line_t         load_data,
  input  wire wb_req_t       wb_req,
  output wb_rsp_t            wb_rsp
);

  line_t mem [2**ADDR_W];
  logic  ack_q;
  line_t dat_q;

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;  // host load, not while running.
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req.cyc && wb_req.stb) begin
      dat_q <= mem[wb_req.adr];
    end
  end

  // single cycle ack so the held request is not served twice.
  always_ff @(posedge clk) begin
    if (rst_internal) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_req.cyc && wb_req.stb && !ack_q;
    end
  end

endmodule

`default_nettype wire

// File: logic/acc_input_top.sv
`timescale 1ns/1ns
`default_nettype none

module acc_input_top import acc_pkg::*; (
  input  wire                          clk,
  input  wire                          rst_internal,
  input  wire                          conf_valid,
  input  wire conf_word_t              conf,
  input  wire [NUM_QUEUES-1:0]         start,
  input  wire                          load_en,
  input  wire [ADDR_W-1:0]             load_addr,
  input  wire line_t                   load_data,
  input  wire [NUM_QUEUES-1:0]         user_rd,
  output wire line_t [NUM_QUEUES-1:0]  user_data,
  output wire [NUM_QUEUES-1:0]         user_valid,
  output wire [NUM_QUEUES-1:0]         user_avail,
  output wire [NUM_QUEUES-1:0]         done
);

  wire [NUM_QUEUES-1:0]         queue_conf_valid;
  wire conf_word_t              queue_conf;
  wire wb_req_t [NUM_QUEUES-1:0] q_req;
  wire wb_rsp_t [NUM_QUEUES-1:0] q_rsp;
  wire wb_req_t                 mem_req;
  wire wb_rsp_t                 mem_rsp;

  conf_receiver u_conf_receiver (
    .clk              (clk),
    .rst_internal     (rst_internal),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .queue_conf_valid (queue_conf_valid),
    .queue_conf       (queue_conf)
  );

  input_queue_controller #(.QUEUE_ID(0)) u_queue0 (
    .clk          (clk),
    .rst_internal (rst_internal),
    .start        (start[0]),
    .conf_valid   (queue_conf_valid),
    .conf         (queue_conf),
    .wb_req       (q_req[0]),
    .wb_rsp       (q_rsp[0]),
    .user_rd      (user_rd[0]),
    .user_data    (user_data[0]),
    .user_valid   (user_valid[0]),
    .user_avail   (user_avail[0]),
    .done         (done[0])
  );

  input_queue_controller #(.QUEUE_ID(1)) u_queue1 (
    .clk          (clk),
    .rst_internal (rst_internal),
    .start        (start[1]),
    .conf_valid   (queue_conf_valid),
    .conf         (queue_conf),
    .wb_req       (q_req[1]),
    .wb_rsp       (q_rsp[1]),
    .user_rd      (user_rd[1]),
    .user_data    (user_data[1]),
    .user_valid   (user_valid[1]),
    .user_avail   (user_avail[1]),
    .done         (done[1])
  );

  read_arbiter u_read_arbiter (
    .clk          (clk),
    .rst_internal (rst_internal),
    .m_req        (q_req),
    .m_rsp        (q_rsp),
    .s_req        (mem_req),
    .s_rsp        (mem_rsp)
  );

  line_memory u_line_memory (
    .clk          (clk),
    .rst_internal (rst_internal),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .wb_req       (mem_req),
    .wb_rsp       (mem_rsp)
  );

endmodule

`default_nettype wire

// File: sim/tb_acc_input.sv
`timescale 1ns/1ns
`default_nettype none

module tb_acc_input import acc_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int LOAD_LINES     = 512;

  logic                   clk;
  logic                   rst_internal;
  logic                   conf_valid;
  conf_word_t             conf;
  logic [NUM_QUEUES-1:0]  start;
  logic                   load_en;
  logic [ADDR_W-1:0]      load_addr;
  line_t                  load_data;
  logic [NUM_QUEUES-1:0]  user_rd;
  line_t [NUM_QUEUES-1:0] user_data;
  logic [NUM_QUEUES-1:0]  user_valid;
  logic [NUM_QUEUES-1:0]  user_avail;
  logic [NUM_QUEUES-1:0]  done;

  line_t                 shadow [2**ADDR_W];  // what the host wrote.
  logic [ADDR_W-1:0]     q_base [NUM_QUEUES];
  logic [QTD_W-1:0]      q_qtd [NUM_QUEUES];
  int                    idx [NUM_QUEUES];
  int                    pop_mode [NUM_QUEUES];  // 0 none, 1 every cycle, 2 random gaps.
  logic [NUM_QUEUES-1:0] rd_next;
  int                    errors;
  int                    test_errors;
  int                    tests_passed;
  int                    tests_failed;
  int                    cycles;

  acc_input_top u_acc_input_top (
    .clk          (clk),
    .rst_internal (rst_internal),
    .conf_valid   (conf_valid),
    .conf         (conf),
    .start        (start),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .user_rd      (user_rd),
    .user_data    (user_data),
    .user_valid   (user_valid),
    .user_avail   (user_avail),
    .done         (done)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // reference and checks
  //////////////////////////////////////////////////

  function automatic line_t expected_line(input int q, input int i);
    return shadow[ADDR_W'(int'(q_base[q]) + i)];  // lines follow the base in order.
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s expected 0x%h actual 0x%h", name, expected, actual);
    end
  endtask

  // every popped line is compared in arrival order.
  always @(negedge clk) begin
    if (!rst_internal) begin
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (user_valid[q]) begin
          check_value($sformatf("user_data[%0d]", q), expected_line(q, idx[q]), user_data[q]);
          idx[q]++;
        end
      end
    end
  end

  // pop pattern is picked on the edge and driven just after it.
  always @(posedge clk) begin
    for (int q = 0; q < NUM_QUEUES; q++) begin
      case (pop_mode[q])
        1:       rd_next[q] = 1'b1;
        2:       rd_next[q] = ($urandom % 4) != 0;
        default: rd_next[q] = 1'b0;
      endcase
    end
    #2;
    user_rd = rd_next;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles, done never reached", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_reset();
    rst_internal = 1'b1;
    start        = '0;
    conf_valid   = 1'b0;
    for (int q = 0; q < NUM_QUEUES; q++) begin
      pop_mode[q] = 0;
    end
    repeat (3) tick();
    rst_internal = 1'b0;
    for (int q = 0; q < NUM_QUEUES; q++) begin
      idx[q] = 0;
    end
  endtask

  task automatic load_lines(input int n);
    for (int a = 0; a < n; a++) begin
      load_en   = 1'b1;
      load_addr = ADDR_W'(a);
      load_data = {$urandom, $urandom};
      shadow[a] = load_data;
      tick();
    end
    load_en = 1'b0;
  endtask

  task automatic send_conf(input int base, input int qtd, input int id);
    conf_valid     = 1'b1;
    conf.addr_base = ADDR_W'(base);
    conf.qtd       = QTD_W'(qtd);
    conf.queue_id  = ID_W'(id);
    if (id < NUM_QUEUES) begin
      q_base[id] = ADDR_W'(base);  // unknown ids reach no queue.
      q_qtd[id]  = QTD_W'(qtd);
    end
    tick();
    conf_valid = 1'b0;
    repeat (2) tick();
  endtask

  task automatic wait_done(input logic [NUM_QUEUES-1:0] mask);
    while ((done & mask) != mask) begin
      tick();
    end
  endtask

  task automatic drain_and_count(input logic [NUM_QUEUES-1:0] mask);
    while ((user_avail & mask) != '0) begin
      tick();
    end
    repeat (2) tick();
    for (int q = 0; q < NUM_QUEUES; q++) begin
      if (mask[q]) begin
        check_value($sformatf("line_count[%0d]", q), 64'(q_qtd[q]), 64'(idx[q]));
      end
    end
  endtask

  task automatic begin_test();
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_errors);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h7acd_f531));
    clk          = 1'b0;
    rst_internal = 1'b1;
    conf_valid   = 1'b0;
    conf         = '0;
    start        = '0;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    user_rd      = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles       = 0;

    begin_test();
    apply_reset();
    check_value("user_valid", '0, user_valid);
    check_value("user_avail", '0, user_avail);
    check_value("done", '0, done);
    end_test("reset_state");

    begin_test();
    pop_mode[0] = 1;  // nothing configured, fifo stays empty.
    pop_mode[1] = 1;
    repeat (4) begin
      tick();
      check_value("user_valid", '0, user_valid);
    end
    end_test("pop_while_empty");

    load_lines(LOAD_LINES);

    begin_test();
    apply_reset();
    send_conf(40, 20, 0);
    pop_mode[0] = 1;
    start[0] = 1'b1;
    wait_done(2'b01);
    drain_and_count(2'b01);
    end_test("single_queue");

    begin_test();
    apply_reset();
    send_conf(100, 16, 0);
    send_conf(300, 18, 1);
    pop_mode[0] = 2;
    pop_mode[1] = 2;
    start = 2'b11;
    wait_done(2'b11);
    drain_and_count(2'b11);
    end_test("two_queues");

    begin_test();
    apply_reset();
    send_conf(400, 40, 1);
    start[1] = 1'b1;
    repeat (200) tick();  // fifo fills, then requests stall.
    check_value("user_avail[1]", 1, user_avail[1]);
    check_value("done[1]", 0, done[1]);
    check_value("line_count[1]", 0, 64'(idx[1]));
    pop_mode[1] = 2;
    wait_done(2'b10);
    drain_and_count(2'b10);
    end_test("back_pressure");

    begin_test();
    apply_reset();
    send_conf(200, 12, 0);
    send_conf(250, 10, 1);
    send_conf(450, 30, 3);  // must reach neither queue.
    pop_mode[0] = 1;
    pop_mode[1] = 1;
    start = 2'b11;
    wait_done(2'b11);
    drain_and_count(2'b11);
    end_test("bad_conf_id");

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
logic/acc_pkg.sv
logic/conf_receiver.sv
logic/sync_fifo.sv
logic/input_queue_controller.sv
logic/read_arbiter.sv
logic/line_memory.sv
logic/acc_input_top.sv
sim/tb_acc_input.sv

// File: Bender.yml
package:
  name: acc_input

sources:
  - target: rtl
    files:
      - logic/acc_pkg.sv
      - logic/conf_receiver.sv
      - logic/sync_fifo.sv
      - logic/input_queue_controller.sv
      - logic/read_arbiter.sv
      - logic/line_memory.sv
      - logic/acc_input_top.sv
  - target: sim
    files:
      - sim/tb_acc_input.sv
